// File: vlog.f
design/pcie_pkg.sv
design/regs_pkg.sv
design/apb_if.sv
design/stream_skid.sv
design/cq_decode.sv
design/ctrl_regfile.sv
design/cc_result.sv
design/ctrl_bar_top.sv
bench/tb_ctrl_bar.sv

// File: Bender.yml
package:
  name: ctrl_bar

sources:
  - design/pcie_pkg.sv
  - design/regs_pkg.sv
  - design/apb_if.sv
  - design/stream_skid.sv
  - design/cq_decode.sv
  - design/ctrl_regfile.sv
  - design/cc_result.sv
  - design/ctrl_bar_top.sv
  - target: test
    files:
      - bench/tb_ctrl_bar.sv

// File: bench/tb_ctrl_bar.sv
// Testbench for the control BAR completer with random requests checked against a register model
`timescale 1ns/1ps

module tb_ctrl_bar;

    localparam int         ADDR_W      = 24;
    localparam logic [2:0] ST_SC       = 3'd0;
    localparam logic [2:0] ST_UR       = 3'd1;
    localparam int         N_SCRATCH   = 20;
    localparam int         N_MIX       = 200;
    localparam int         TOTAL_REQ   = 1 + 8 + 2 * N_SCRATCH + 33 + N_MIX;
    localparam int         CYCLE_LIMIT = 4 * TOTAL_REQ * 10;

    // ID words, listed from index 7 down to index 0
    localparam logic [7:0][31:0] ID_WORDS = {
        32'h7E1E_A5E0, 32'hC0FF_EE42, 32'h3A9C_0B1D, 32'hB0A2_D002,
        32'h0ADD_0001, 32'h0002_0304, 32'hF1F0_0123, 32'hA5C3_0001
    };

    typedef struct packed {
        logic [2:0]  status;
        logic [31:0] data;
        logic [7:0]  tag;
        logic [15:0] req_id;
        logic [6:0]  lower_addr;
    } cpl_t;

    logic              pcie_clk = 1'b0;
    logic              pcie_rst;
    logic              cq_valid;
    logic              cq_ready;
    logic              cq_write;
    logic [ADDR_W-1:0] cq_addr;
    logic [31:0]       cq_data;
    logic [3:0]        cq_first_be;
    logic [7:0]        cq_tag;
    logic [15:0]       cq_req_id;
    logic              cc_valid;
    logic              cc_ready;
    logic [2:0]        cc_status;
    logic [31:0]       cc_data;
    logic [7:0]        cc_tag;
    logic [15:0]       cc_req_id;
    logic [6:0]        cc_lower_addr;

    logic [31:0] lcg_state = 32'h86b7;
    logic [31:0] scratch_model = '0;
    cpl_t        exp_q [$];
    logic        rand_ready = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          n_cpl = 0;
    int          cycles = 0;

    ctrl_bar_top #(
        .fpga_id(ID_WORDS[0]), .fw_id(ID_WORDS[1]), .fw_ver(ID_WORDS[2]),
        .board_id(ID_WORDS[3]), .board_ver(ID_WORDS[4]), .build_date(ID_WORDS[5]),
        .git_hash(ID_WORDS[6]), .release_info(ID_WORDS[7])
    ) dut_i (
        .pcie_clk(pcie_clk), .pcie_rst(pcie_rst),
        .cq_valid(cq_valid), .cq_ready(cq_ready), .cq_write(cq_write), .cq_addr(cq_addr),
        .cq_data(cq_data), .cq_first_be(cq_first_be), .cq_tag(cq_tag), .cq_req_id(cq_req_id),
        .cc_valid(cc_valid), .cc_ready(cc_ready), .cc_status(cc_status), .cc_data(cc_data),
        .cc_tag(cc_tag), .cc_req_id(cc_req_id), .cc_lower_addr(cc_lower_addr)
    );

    always #4 pcie_clk = ~pcie_clk;

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Mostly mapped offsets with some scratch and unmapped ones
    function automatic logic [ADDR_W-1:0] pick_addr();
        logic [31:0] r;
        r = rand32();
        case (r[31:30])
            2'd0, 2'd1: return ADDR_W'(r[7:0] % 9);
            2'd2:       return ADDR_W'(8);
            default:    return r[29] ? ADDR_W'(9 + r[2:0] % 7) : (ADDR_W'(r[21:0]) | 24'h10);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic next_fall();
        @(negedge pcie_clk);
        if (rand_ready) begin
            cc_ready = rand32() >> 31;
        end
    endtask

    task automatic send_req(input logic wr, input logic [ADDR_W-1:0] dw,
                            input logic [31:0] data, input logic [3:0] be);
        cpl_t        exp;
        logic [31:0] r;
        logic [25:0] byte_addr;
        r = rand32();
        byte_addr = {dw, 2'b00};
        next_fall();
        cq_valid = 1'b1;
        cq_write = wr;
        cq_addr = dw;
        cq_data = data;
        cq_first_be = be;
        cq_tag = r[7:0];
        cq_req_id = r[23:8];
        @(posedge pcie_clk);
        while (!cq_ready) begin
            next_fall();
            @(posedge pcie_clk);
        end
        if (wr) begin
            // Only the scratch word takes writes, byte by byte
            if (dw == ADDR_W'(8)) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        scratch_model[8*i +: 8] = data[8*i +: 8];
                    end
                end
            end
        end else begin
            exp.tag = r[7:0];
            exp.req_id = r[23:8];
            exp.lower_addr = byte_addr[6:0];
            if (byte_addr <= 26'h20) begin
                exp.status = ST_SC;
                exp.data = (dw == ADDR_W'(8)) ? scratch_model : ID_WORDS[dw[2:0]];
            end else begin
                exp.status = ST_UR;
                exp.data = '0;
            end
            exp_q.push_back(exp);
        end
    endtask

    task automatic drain();
        next_fall();
        cq_valid = 1'b0;
        while (exp_q.size() != 0) begin
            next_fall();
        end
        // Room for a stray completion to show up
        repeat (8) next_fall();
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - err_start);
        end
    endtask

    // Compare each accepted completion in order
    always @(posedge pcie_clk) begin : cpl_monitor
        cpl_t exp;
        if (!pcie_rst && cc_valid && cc_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Completion with tag 0x%02h arrived with no read outstanding", cc_tag);
            end else begin
                exp = exp_q.pop_front();
                n_cpl++;
                check_value("cc_status", cc_status, exp.status);
                check_value("cc_data", cc_data, exp.data);
                check_value("cc_tag", cc_tag, exp.tag);
                check_value("cc_req_id", cc_req_id, exp.req_id);
                check_value("cc_lower_addr", cc_lower_addr, exp.lower_addr);
            end
        end
    end

    always @(posedge pcie_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles with %0d completions still missing",
                     cycles, exp_q.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int err0;
        pcie_rst = 1'b1;
        cq_valid = 1'b0;
        cq_write = 1'b0;
        cq_addr = '0;
        cq_data = '0;
        cq_first_be = '0;
        cq_tag = '0;
        cq_req_id = '0;
        cc_ready = 1'b1;
        repeat (3) @(posedge pcie_clk);
        @(negedge pcie_clk);
        pcie_rst = 1'b0;

        err0 = errors;
        check_value("cc_valid", cc_valid, 32'd0);
        // Input skid opens one cycle after reset release
        check_value("cq_ready", cq_ready, 32'd0);
        next_fall();
        check_value("cq_ready", cq_ready, 32'd1);
        send_req(1'b0, ADDR_W'(8), rand32(), 4'hF);
        drain();
        report_test("reset state", err0);

        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            send_req(1'b0, ADDR_W'(i), rand32(), rand32() >> 28);
        end
        drain();
        report_test("ID words", err0);

        err0 = errors;
        for (int i = 0; i < N_SCRATCH; i++) begin
            send_req(1'b1, ADDR_W'(8), rand32(), rand32() >> 28);
            send_req(1'b0, ADDR_W'(8), rand32(), 4'hF);
        end
        drain();
        report_test("scratch byte writes", err0);

        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            send_req(1'b1, ADDR_W'(i), rand32(), 4'hF);
            send_req(1'b1, pick_addr() | 24'h10, rand32(), 4'hF);
            send_req(1'b0, ADDR_W'(9 + i % 7), rand32(), 4'hF);
        end
        send_req(1'b0, ADDR_W'(8), rand32(), 4'hF);
        for (int i = 0; i < 8; i++) begin
            send_req(1'b0, ADDR_W'(i), rand32(), 4'hF);
        end
        drain();
        report_test("unmapped and read-only", err0);

        err0 = errors;
        rand_ready = 1'b1;
        for (int i = 0; i < N_MIX; i++) begin
            send_req(rand32() >> 31, pick_addr(), rand32(), rand32() >> 28);
        end
        drain();
        rand_ready = 1'b0;
        cc_ready = 1'b1;
        drain();
        report_test("random mix with back-pressure", err0);

        $display("Summary: %0d checks, %0d errors, %0d completions", checks, errors, n_cpl);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: design/ctrl_bar_top.sv
// Control BAR completer pipeline from request stream through APB registers to completions
`timescale 1ns/1ps

module ctrl_bar_top #(
    parameter int ctrl_addr_w = pcie_pkg::CTRL_ADDR_W,
    parameter logic [31:0] fpga_id      = regs_pkg::DEF_FPGA_ID,
    parameter logic [31:0] fw_id        = regs_pkg::DEF_FW_ID,
    parameter logic [31:0] fw_ver       = regs_pkg::DEF_FW_VER,
    parameter logic [31:0] board_id     = regs_pkg::DEF_BOARD_ID,
    parameter logic [31:0] board_ver    = regs_pkg::DEF_BOARD_VER,
    parameter logic [31:0] build_date   = regs_pkg::DEF_BUILD_DATE,
    parameter logic [31:0] git_hash     = regs_pkg::DEF_GIT_HASH,
    parameter logic [31:0] release_info = regs_pkg::DEF_RELEASE_INFO
) (
    input  logic                             pcie_clk,
    input  logic                             pcie_rst,
    input  logic                             cq_valid,
    output logic                             cq_ready,
    input  logic                             cq_write,
    input  logic [pcie_pkg::CTRL_ADDR_W-1:0] cq_addr,
    input  logic [31:0]                      cq_data,
    input  logic [3:0]                       cq_first_be,
    input  logic [7:0]                       cq_tag,
    input  logic [15:0]                      cq_req_id,
    output logic                             cc_valid,
    input  logic                             cc_ready,
    output logic [2:0]                       cc_status,
    output logic [31:0]                      cc_data,
    output logic [7:0]                       cc_tag,
    output logic [15:0]                      cc_req_id,
    output logic [6:0]                       cc_lower_addr
);
    import pcie_pkg::*;

    cq_req_t    cq_in;
    cq_req_t    req;
    logic       req_valid;
    logic       req_ready;
    rd_result_t res;
    logic       res_valid;
    cc_cpl_t    cpl;
    logic       cpl_valid;
    logic       cpl_space;
    cc_cpl_t    cc_out;

    assign cq_in.write = cq_write;
    assign cq_in.addr = cq_addr;
    assign cq_in.data = cq_data;
    assign cq_in.first_be = cq_first_be;
    assign cq_in.tag = cq_tag;
    assign cq_in.req_id = cq_req_id;

    apb_if #(.addr_w(ctrl_addr_w)) apb ();

    stream_skid #(.payload_t(cq_req_t)) cq_skid_i (
        .pcie_clk(pcie_clk), .pcie_rst(pcie_rst),
        .in_valid(cq_valid), .in_ready(cq_ready), .in_data(cq_in),
        .out_valid(req_valid), .out_ready(req_ready), .out_data(req)
    );

    cq_decode #(.ctrl_addr_w(ctrl_addr_w)) cq_decode_i (
        .pcie_clk(pcie_clk), .pcie_rst(pcie_rst),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .cpl_space(cpl_space), .apb(apb),
        .res_valid(res_valid), .res(res)
    );

    ctrl_regfile #(
        .ctrl_addr_w(ctrl_addr_w), .fpga_id(fpga_id), .fw_id(fw_id), .fw_ver(fw_ver),
        .board_id(board_id), .board_ver(board_ver), .build_date(build_date),
        .git_hash(git_hash), .release_info(release_info)
    ) ctrl_regfile_i (
        .pcie_clk(pcie_clk), .pcie_rst(pcie_rst), .apb(apb)
    );

    cc_result cc_result_i (
        .pcie_clk(pcie_clk), .pcie_rst(pcie_rst),
        .res_valid(res_valid), .res(res), .cpl_valid(cpl_valid), .cpl(cpl)
    );

    // Its ready doubles as the read launch permit in the decoder
    stream_skid #(.payload_t(cc_cpl_t)) cc_skid_i (
        .pcie_clk(pcie_clk), .pcie_rst(pcie_rst),
        .in_valid(cpl_valid), .in_ready(cpl_space), .in_data(cpl),
        .out_valid(cc_valid), .out_ready(cc_ready), .out_data(cc_out)
    );

    assign cc_status = cc_out.status;
    assign cc_data = cc_out.data;
    assign cc_tag = cc_out.tag;
    assign cc_req_id = cc_out.req_id;
    assign cc_lower_addr = cc_out.lower_addr;

endmodule

// File: design/cc_result.sv
// Completion formatter that turns read results into completion payloads
`timescale 1ns/1ps

module cc_result (
    input  logic                 pcie_clk,
    input  logic                 pcie_rst,
    input  logic                 res_valid,
    input  pcie_pkg::rd_result_t res,
    output logic                 cpl_valid,
    output pcie_pkg::cc_cpl_t    cpl
);
    import pcie_pkg::*;

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            cpl_valid <= 1'b0;
        end else begin
            cpl_valid <= res_valid;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (res_valid) begin
            // Failed read turns into Unsupported Request with no data
            if (res.err) begin
                cpl.status <= CPL_UR;
                cpl.data <= '0;
            end else begin
                cpl.status <= CPL_SC;
                cpl.data <= res.data;
            end
            cpl.tag <= res.tag;
            cpl.req_id <= res.req_id;
            // Lower address is byte address bits 6:0
            cpl.lower_addr <= res.addr_lo;
        end
    end

endmodule

// File: design/ctrl_regfile.sv
// Control register file on APB with ID words, a scratch register and error response
`timescale 1ns/1ps

module ctrl_regfile #(
    parameter int ctrl_addr_w = pcie_pkg::CTRL_ADDR_W,
    parameter logic [regs_pkg::APB_DATA_W-1:0] fpga_id      = regs_pkg::DEF_FPGA_ID,
    parameter logic [regs_pkg::APB_DATA_W-1:0] fw_id        = regs_pkg::DEF_FW_ID,
    parameter logic [regs_pkg::APB_DATA_W-1:0] fw_ver       = regs_pkg::DEF_FW_VER,
    parameter logic [regs_pkg::APB_DATA_W-1:0] board_id     = regs_pkg::DEF_BOARD_ID,
    parameter logic [regs_pkg::APB_DATA_W-1:0] board_ver    = regs_pkg::DEF_BOARD_VER,
    parameter logic [regs_pkg::APB_DATA_W-1:0] build_date   = regs_pkg::DEF_BUILD_DATE,
    parameter logic [regs_pkg::APB_DATA_W-1:0] git_hash     = regs_pkg::DEF_GIT_HASH,
    parameter logic [regs_pkg::APB_DATA_W-1:0] release_info = regs_pkg::DEF_RELEASE_INFO
) (
    input  logic     pcie_clk,
    input  logic     pcie_rst,
    apb_if.completer apb
);
    import regs_pkg::*;

    logic [REG_OFF_W-1:0]  off;
    logic                  mapped;
    logic                  access;
    logic                  rd_wait;
    logic [APB_DATA_W-1:0] rd_mux;
    logic [APB_DATA_W-1:0] prdata_q;
    logic [APB_DATA_W-1:0] scratch;

    assign off = apb.paddr[REG_OFF_W-1:0];
    // Anything past the scratch word or outside the 64 byte window is unmapped
    assign mapped = !(|apb.paddr[ctrl_addr_w-1:REG_OFF_W]) && (off <= REG_LAST);
    assign access = apb.psel && apb.penable;

    always_comb begin
        case (off)
            REG_FPGA_ID:      rd_mux = fpga_id;
            REG_FW_ID:        rd_mux = fw_id;
            REG_FW_VER:       rd_mux = fw_ver;
            REG_BOARD_ID:     rd_mux = board_id;
            REG_BOARD_VER:    rd_mux = board_ver;
            REG_BUILD_DATE:   rd_mux = build_date;
            REG_GIT_HASH:     rd_mux = git_hash;
            REG_RELEASE_INFO: rd_mux = release_info;
            REG_SCRATCH:      rd_mux = scratch;
            default:          rd_mux = '0;
        endcase
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            rd_wait <= 1'b0;
            scratch <= '0;
        end else begin
            // High in the second access cycle of a read
            rd_wait <= access && !apb.pwrite && !rd_wait;
            if (access && apb.pwrite && mapped && (off == REG_SCRATCH)) begin
                for (int i = 0; i < APB_STRB_W; i++) begin
                    if (apb.pstrb[i]) begin
                        scratch[8*i +: 8] <= apb.pwdata[8*i +: 8];
                    end
                end
            end
        end
    end

    // Read mux sampled in the first access cycle
    always_ff @(posedge pcie_clk) begin
        if (access && !apb.pwrite && !rd_wait) begin
            prdata_q <= mapped ? rd_mux : '0;
        end
    end

    assign apb.prdata = prdata_q;
    assign apb.pready = access && (apb.pwrite || rd_wait);
    // ID word writes fall through silently, only unmapped offsets flag an error
    assign apb.pslverr = access && !mapped;

endmodule

// File: design/cq_decode.sv
// Request decoder that runs one APB transfer per request and forwards read results
`timescale 1ns/1ps

module cq_decode #(
    parameter int ctrl_addr_w = pcie_pkg::CTRL_ADDR_W
) (
    input  logic                 pcie_clk,
    input  logic                 pcie_rst,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  pcie_pkg::cq_req_t    req,
    input  logic                 cpl_space,
    apb_if.requester             apb,
    output logic                 res_valid,
    output pcie_pkg::rd_result_t res
);
    import pcie_pkg::*;
    import regs_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t  state;
    cq_req_t req_q;
    // Read result sitting in the completion formatter this cycle
    logic    res_pend;
    logic    take;
    logic    done;

    // A read needs a free output slot with nothing else on its way there.
    // Whatever follows a blocked read waits too, keeping strict order
    assign req_ready = (state == st_idle) &&
                       (req.write || (cpl_space && !res_valid && !res_pend));
    assign take = req_valid && req_ready;
    assign done = (state == st_access) && apb.pready;

    assign apb.psel = (state != st_idle);
    assign apb.penable = (state == st_access);
    assign apb.pwrite = req_q.write;
    // Dword address to byte address
    assign apb.paddr = ctrl_addr_w'({req_q.addr, 2'b00});
    assign apb.pwdata = req_q.data;
    assign apb.pstrb = req_q.write ? APB_STRB_W'(req_q.first_be) : '0;

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            state <= st_idle;
            res_valid <= 1'b0;
            res_pend <= 1'b0;
        end else begin
            res_valid <= done && !req_q.write;
            res_pend <= res_valid;
            case (state)
                st_idle: begin
                    if (take) begin
                        state <= st_setup;
                    end
                end
                st_setup: begin
                    state <= st_access;
                end
                st_access: begin
                    if (apb.pready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (take) begin
            req_q <= req;
        end
        // prdata and pslverr only hold in the pready cycle
        if (done) begin
            res.tag <= req_q.tag;
            res.req_id <= req_q.req_id;
            res.addr_lo <= {req_q.addr[4:0], 2'b00};
            res.data <= apb.prdata;
            res.err <= apb.pslverr;
        end
    end

endmodule

// File: design/stream_skid.sv
// Two-entry valid/ready skid buffer with registered ready, for any payload type
`timescale 1ns/1ps

module stream_skid #(
    parameter type payload_t = logic
) (
    input  logic     pcie_clk,
    input  logic     pcie_rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    payload_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic [1:0] count_next;
    logic       in_ready_q;
    logic       push;
    logic       pop;

    assign push = in_valid && in_ready_q;
    assign pop = out_valid && out_ready;
    assign count_next = count + {1'b0, push} - {1'b0, pop};

    always_ff @(posedge pcie_clk) begin
        if (pcie_rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
            in_ready_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count_next;
            // Ready from next fill level, no combinational path upstream
            in_ready_q <= (count_next != 2'd2);
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    assign in_ready = in_ready_q;
    assign out_valid = (count != 2'd0);
    assign out_data = mem[rd_ptr];

endmodule

// File: design/apb_if.sv
// APB link between the request decoder and the control register file
`timescale 1ns/1ps

interface apb_if #(
    parameter int addr_w = pcie_pkg::CTRL_ADDR_W
);
    import regs_pkg::*;

    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [addr_w-1:0]     paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_STRB_W-1:0] pstrb;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    modport requester (
        output psel, penable, pwrite, paddr, pwdata, pstrb,
        input  prdata, pready, pslverr
    );

    modport completer (
        input  psel, penable, pwrite, paddr, pwdata, pstrb,
        output prdata, pready, pslverr
    );

endinterface

// File: design/regs_pkg.sv
// Control register map with ID word offsets, default ID values and APB widths
package regs_pkg;

    localparam int APB_DATA_W = 32;
    localparam int APB_STRB_W = APB_DATA_W / 8;

    // Register window is 64 bytes
    localparam int REG_OFF_W = 6;

    // Byte offsets
    localparam logic [REG_OFF_W-1:0] REG_FPGA_ID      = 6'h00;
    localparam logic [REG_OFF_W-1:0] REG_FW_ID        = 6'h04;
    localparam logic [REG_OFF_W-1:0] REG_FW_VER       = 6'h08;
    localparam logic [REG_OFF_W-1:0] REG_BOARD_ID     = 6'h0C;
    localparam logic [REG_OFF_W-1:0] REG_BOARD_VER    = 6'h10;
    localparam logic [REG_OFF_W-1:0] REG_BUILD_DATE   = 6'h14;
    localparam logic [REG_OFF_W-1:0] REG_GIT_HASH     = 6'h18;
    localparam logic [REG_OFF_W-1:0] REG_RELEASE_INFO = 6'h1C;
    localparam logic [REG_OFF_W-1:0] REG_SCRATCH      = 6'h20;
    localparam logic [REG_OFF_W-1:0] REG_LAST         = REG_SCRATCH;

    // Default identification words
    localparam logic [APB_DATA_W-1:0] DEF_FPGA_ID      = 32'hDEADBEEF;
    localparam logic [APB_DATA_W-1:0] DEF_FW_ID        = 32'h0000C001;
    localparam logic [APB_DATA_W-1:0] DEF_FW_VER       = 32'h000_01_000;
    localparam logic [APB_DATA_W-1:0] DEF_BOARD_ID     = 32'h1234_0000;
    localparam logic [APB_DATA_W-1:0] DEF_BOARD_VER    = 32'h001_00_000;
    localparam logic [APB_DATA_W-1:0] DEF_BUILD_DATE   = 32'd602976000;
    localparam logic [APB_DATA_W-1:0] DEF_GIT_HASH     = 32'h5f87c2e8;
    localparam logic [APB_DATA_W-1:0] DEF_RELEASE_INFO = 32'h00000000;

endpackage

// File: design/pcie_pkg.sv
// PCIe completer types: request, read result and completion payloads
package pcie_pkg;

    // Width of the control BAR address
    localparam int CTRL_ADDR_W = 24;

    // Completion status codes
    localparam logic [2:0] CPL_SC = 3'd0;
    localparam logic [2:0] CPL_UR = 3'd1;

    // Single dword request from the completer request stream
    typedef struct packed {
        logic                   write;
        logic [CTRL_ADDR_W-1:0] addr;
        logic [31:0]            data;
        logic [3:0]             first_be;
        logic [7:0]             tag;
        logic [15:0]            req_id;
    } cq_req_t;

    // Read outcome handed from the decoder to the completion formatter
    typedef struct packed {
        logic [7:0]  tag;
        logic [15:0] req_id;
        logic [6:0]  addr_lo;
        logic [31:0] data;
        logic        err;
    } rd_result_t;

    // Completion towards the completer completion stream
    typedef struct packed {
        logic [2:0]  status;
        logic [31:0] data;
        logic [7:0]  tag;
        logic [15:0] req_id;
        logic [6:0]  lower_addr;
    } cc_cpl_t;

endpackage
